// ==== include/afu_defines.svh ====
`ifndef AFU_DEFINES_SVH
`define AFU_DEFINES_SVH

// Command tag width and table depth
`define AFU_TAG_BITS        8
`define AFU_TAG_COUNT       256

// Compute unit id
`define AFU_CU_ID_BITS      4

// Half-line layout, one parity bit per doubleword
`define AFU_DOUBLE_WORDS    8
`define AFU_HALF_LINE_BITS  512
`define AFU_DW_BITS         (`AFU_HALF_LINE_BITS / `AFU_DOUBLE_WORDS)

// Full cache line, two halves
`define AFU_LINE_BITS       (2 * `AFU_HALF_LINE_BITS)

`endif

// ==== hdl/afu_pkg.sv ====
`include "afu_defines.svh"

package afu_pkg;

  typedef enum logic [1:0] {
    CMD_INVALID = 2'd0,
    CMD_READ    = 2'd1,
    CMD_WED     = 2'd2,
    CMD_WRITE   = 2'd3
  } cmd_type_t;

  // Host side beat, odd parity on tag and each doubleword
  typedef struct packed {
    logic                             write_valid;
    logic [`AFU_TAG_BITS-1:0]         write_tag;
    logic                             write_tag_parity;
    logic                             write_address;  // Half-line select
    logic [`AFU_HALF_LINE_BITS-1:0]   write_data;
    logic [`AFU_DOUBLE_WORDS-1:0]     write_parity;
  } buffer_write_t;

  typedef struct packed {
    logic                             valid;
    logic [`AFU_TAG_BITS-1:0]         tag;
    logic [`AFU_CU_ID_BITS-1:0]       cu_id;
    cmd_type_t                        cmd_type;
  } cmd_issue_t;

  // Table lookup result
  typedef struct packed {
    logic [`AFU_CU_ID_BITS-1:0]       cu_id;
    cmd_type_t                        cmd_type;
  } command_tag_line_t;

  typedef struct packed {
    logic [`AFU_TAG_BITS-1:0]         tag;
    logic [`AFU_CU_ID_BITS-1:0]       cu_id;
    cmd_type_t                        cmd_type;
    logic [`AFU_HALF_LINE_BITS-1:0]   data;
  } read_line_t;

  typedef struct packed {
    logic                             read_data;
    logic                             wed_data;
    read_line_t                       line;
  } data_control_out_t;

  // Half 0 sits in the low half of data
  typedef struct packed {
    logic                             valid;
    logic                             read_data;
    logic                             wed_data;
    logic [`AFU_TAG_BITS-1:0]         tag;
    logic [`AFU_CU_ID_BITS-1:0]       cu_id;
    logic [`AFU_LINE_BITS-1:0]        data;
  } full_line_t;

endpackage

// ==== hdl/cmd_tag_table.sv ====
`include "afu_defines.svh"

module cmd_tag_table (
  input  logic                         clock,
  input  logic                         rstn,
  input  afu_pkg::cmd_issue_t          cmd_in,
  input  logic [`AFU_TAG_BITS-1:0]     lookup_tag,
  output afu_pkg::command_tag_line_t   tag_line
);

  afu_pkg::command_tag_line_t entries [`AFU_TAG_COUNT];

  ////////////////////////////////////////////////////////////////////////////
  // Table write on command issue
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < `AFU_TAG_COUNT; i++) begin
        entries[i].cu_id    <= '0;
        entries[i].cmd_type <= afu_pkg::CMD_INVALID;  // No tag outstanding
      end
    end else if (cmd_in.valid) begin
      // Reissue of a live tag simply overwrites it
      entries[cmd_in.tag].cu_id    <= cmd_in.cu_id;
      entries[cmd_in.tag].cmd_type <= cmd_in.cmd_type;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup port
  ////////////////////////////////////////////////////////////////////////////

  // Same-cycle read for the steering stage
  assign tag_line = entries[lookup_tag];

endmodule

// ==== hdl/read_data_control.sv ====
`include "afu_defines.svh"

module read_data_control (
  input  logic                               clock,
  input  logic                               rstn,
  input  logic                               enabled,
  input  afu_pkg::buffer_write_t             buffer_in,
  input  afu_pkg::command_tag_line_t         tag_line,
  output logic [`AFU_TAG_BITS-1:0]           lookup_tag,
  output logic [1:0]                         data_read_error,  // [0] tag, [1] data
  output afu_pkg::data_control_out_t         half_0,
  output afu_pkg::data_control_out_t         half_1
);

  afu_pkg::buffer_write_t          buffer_latched;
  logic                            steer_0;
  logic                            steer_1;
  logic                            tag_parity_calc;
  logic [`AFU_DOUBLE_WORDS-1:0]    dw_parity_calc;
  logic                            tag_parity_error;
  logic                            data_parity_error;

  ////////////////////////////////////////////////////////////////////////////
  // Input latch
  ////////////////////////////////////////////////////////////////////////////

  // Beat and its parity bits land together
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      buffer_latched <= '0;
    end else if (enabled) begin
      buffer_latched <= buffer_in;
    end else begin
      buffer_latched <= '0;  // Beat dropped while disabled
    end
  end

  assign lookup_tag = buffer_latched.write_tag;

  ////////////////////////////////////////////////////////////////////////////
  // Half-line steering
  ////////////////////////////////////////////////////////////////////////////

  assign steer_0 = buffer_latched.write_valid & ~buffer_latched.write_address;
  assign steer_1 = buffer_latched.write_valid &  buffer_latched.write_address;

  // Tag context and command class for one half
  function automatic afu_pkg::data_control_out_t build_half(
    input afu_pkg::buffer_write_t      beat,
    input afu_pkg::command_tag_line_t  entry
  );
    afu_pkg::data_control_out_t h;
    h = '0;
    case (entry.cmd_type)
      afu_pkg::CMD_READ: h.read_data = 1'b1;
      afu_pkg::CMD_WED:  h.wed_data  = 1'b1;
      default: ;                             // Neither flag
    endcase
    h.line.tag      = beat.write_tag;
    h.line.cu_id    = entry.cu_id;
    h.line.cmd_type = entry.cmd_type;
    h.line.data     = beat.write_data;
    return h;
  endfunction

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      half_0 <= '0;
    end else if (steer_0) begin
      half_0 <= build_half(buffer_latched, tag_line);
    end else begin
      half_0 <= '0;  // One-cycle level per beat
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      half_1 <= '0;
    end else if (steer_1) begin
      half_1 <= build_half(buffer_latched, tag_line);
    end else begin
      half_1 <= '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Odd parity recompute
  ////////////////////////////////////////////////////////////////////////////

  // Parity bit makes the count of ones odd
  assign tag_parity_calc = ~^buffer_latched.write_tag;

  always_comb begin
    for (int i = 0; i < `AFU_DOUBLE_WORDS; i++) begin
      dw_parity_calc[i] = ~^buffer_latched.write_data[i*`AFU_DW_BITS +: `AFU_DW_BITS];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_parity_error  <= 1'b0;
      data_parity_error <= 1'b0;
    end else if (buffer_latched.write_valid) begin
      tag_parity_error  <= tag_parity_calc ^ buffer_latched.write_tag_parity;
      data_parity_error <= |(dw_parity_calc ^ buffer_latched.write_parity);
    end else begin
      tag_parity_error  <= 1'b0;
      data_parity_error <= 1'b0;
    end
  end

  // Second stage, one-cycle report
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      data_read_error <= 2'b00;
    end else begin
      data_read_error <= {data_parity_error, tag_parity_error};
    end
  end

endmodule

// ==== hdl/read_line_assembler.sv ====
module read_line_assembler (
  input  logic                          clock,
  input  logic                          rstn,
  input  afu_pkg::data_control_out_t    half_0,
  input  afu_pkg::data_control_out_t    half_1,
  output afu_pkg::full_line_t           line_out,
  output logic                          line_error
);

  afu_pkg::data_control_out_t  pending;
  logic                        pending_valid;
  logic                        arrive_0;
  logic                        arrive_1;
  logic                        pair_match;

  // Only halves of tracked read or WED commands take part
  assign arrive_0 = half_0.read_data | half_0.wed_data;
  assign arrive_1 = half_1.read_data | half_1.wed_data;

  assign pair_match = pending_valid && (pending.line.tag == half_1.line.tag);

  ////////////////////////////////////////////////////////////////////////////
  // Pending half 0
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      pending_valid <= 1'b0;
    end else if (arrive_0) begin
      pending_valid <= 1'b1;  // Newer half 0 replaces the old one
    end else if (arrive_1 && pair_match) begin
      pending_valid <= 1'b0;
    end
  end

  // Payload only, qualified by pending_valid
  always_ff @(posedge clock) begin
    if (arrive_0) begin
      pending <= half_0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Line output and order check
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      line_out   <= '0;
      line_error <= 1'b0;
    end else begin
      line_out   <= '0;
      line_error <= 1'b0;
      if (arrive_1) begin
        if (pair_match) begin
          line_out.valid     <= 1'b1;
          line_out.read_data <= pending.read_data;
          line_out.wed_data  <= pending.wed_data;
          line_out.tag       <= pending.line.tag;
          line_out.cu_id     <= half_1.line.cu_id;
          line_out.data      <= {half_1.line.data, pending.line.data};
        end else begin
          line_error <= 1'b1;  // Unpaired half 1 is dropped
        end
      end
    end
  end

endmodule

// ==== hdl/read_data_top.sv ====
`include "afu_defines.svh"

module read_data_top (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enabled,
  input  afu_pkg::cmd_issue_t        cmd_in,
  input  afu_pkg::buffer_write_t     buffer_in,
  output afu_pkg::full_line_t        line_out,
  output logic [1:0]                 data_read_error,
  output logic                       line_error
);

  logic [`AFU_TAG_BITS-1:0]      lookup_tag;
  afu_pkg::command_tag_line_t    tag_line;
  afu_pkg::data_control_out_t    half_0;
  afu_pkg::data_control_out_t    half_1;

  ////////////////////////////////////////////////////////////////////////////
  // Tag table, control stage, line assembly
  ////////////////////////////////////////////////////////////////////////////

  cmd_tag_table u_cmd_tag_table (
    .clock      (clock),
    .rstn       (rstn),
    .cmd_in     (cmd_in),
    .lookup_tag (lookup_tag),
    .tag_line   (tag_line)
  );

  read_data_control u_read_data_control (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .buffer_in       (buffer_in),
    .tag_line        (tag_line),
    .lookup_tag      (lookup_tag),
    .data_read_error (data_read_error),
    .half_0          (half_0),
    .half_1          (half_1)
  );

  // Pairs the two halves by tag
  read_line_assembler u_read_line_assembler (
    .clock      (clock),
    .rstn       (rstn),
    .half_0     (half_0),
    .half_1     (half_1),
    .line_out   (line_out),
    .line_error (line_error)
  );

endmodule

// ==== tests/read_data_checker.sv ====
module read_data_checker (
  input  logic                          clock,
  input  logic                          rstn,
  input  logic                          enabled,
  input  afu_pkg::buffer_write_t        buffer_in,
  input  afu_pkg::data_control_out_t    half_0,
  input  afu_pkg::data_control_out_t    half_1
);

  int   failure_count = 0;
  logic loaded_0;
  logic loaded_1;

  assign loaded_0 = (half_0 != '0);
  assign loaded_1 = (half_1 != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Steering properties
  ////////////////////////////////////////////////////////////////////////////

  halves_exclusive: assert property (@(posedge clock) disable iff (!rstn)
    !(loaded_0 && loaded_1))
    else begin
      failure_count++;
      $error("half_0 and half_1 were loaded in the same cycle");
    end

  // One command class per half
  class_exclusive: assert property (@(posedge clock) disable iff (!rstn)
    !(half_0.read_data && half_0.wed_data) && !(half_1.read_data && half_1.wed_data))
    else begin
      failure_count++;
      $error("read_data and wed_data were both set on one half");
    end

  // Latch at the first edge and half register at the second
  beat_lands: assert property (@(posedge clock) disable iff (!rstn)
    (buffer_in.write_valid && enabled) |-> ##2 (loaded_0 ^ loaded_1))
    else begin
      failure_count++;
      $error("an enabled beat did not load exactly one half two cycles later");
    end

endmodule

// ==== tests/read_data_tb.sv ====
`include "afu_defines.svh"

module read_data_tb;

  localparam int CLOCK_PERIOD    = 10;
  localparam int RESET_CYCLES    = 5;
  localparam int TEST_COUNT      = 6;
  localparam int CYCLES_PER_TEST = 40;

  logic                     clock;
  logic                     rstn;
  logic                     enabled;
  afu_pkg::cmd_issue_t      cmd_in;
  afu_pkg::buffer_write_t   buffer_in;
  afu_pkg::full_line_t      line_out;
  logic [1:0]               data_read_error;
  logic                     line_error;
  logic [15:0]              lfsr_state;

  read_data_top UUT (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .cmd_in          (cmd_in),
    .buffer_in       (buffer_in),
    .line_out        (line_out),
    .data_read_error (data_read_error),
    .line_error      (line_error)
  );

  bind read_data_control read_data_checker u_read_data_checker (
    .clock     (clock),
    .rstn      (rstn),
    .enabled   (enabled),
    .buffer_in (buffer_in),
    .half_0    (half_0),
    .half_1    (half_1)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic feedback;
    feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], feedback};
    return feedback;
  endfunction

  function automatic logic [`AFU_HALF_LINE_BITS-1:0] random_half();
    logic [`AFU_HALF_LINE_BITS-1:0] value;
    for (int i = 0; i < `AFU_HALF_LINE_BITS; i++) begin
      value[i] = lfsr_bit();
    end
    return value;
  endfunction

  // Bit that makes the total count of ones odd
  function automatic logic odd_parity(input logic [`AFU_DW_BITS-1:0] value);
    int ones;
    ones = 0;
    for (int i = 0; i < `AFU_DW_BITS; i++) begin
      ones += value[i];
    end
    return (ones % 2 == 0);
  endfunction

  function automatic afu_pkg::buffer_write_t make_beat(
    input logic [`AFU_TAG_BITS-1:0]        tag,
    input logic                            address,
    input logic [`AFU_HALF_LINE_BITS-1:0]  data,
    input logic                            flip_tag,
    input int                              flip_dw     // -1 for none
  );
    afu_pkg::buffer_write_t beat;
    beat.write_valid      = 1'b1;
    beat.write_tag        = tag;
    beat.write_tag_parity = odd_parity(tag) ^ flip_tag;
    beat.write_address    = address;
    beat.write_data       = data;
    for (int i = 0; i < `AFU_DOUBLE_WORDS; i++) begin
      beat.write_parity[i] = odd_parity(data[i*`AFU_DW_BITS +: `AFU_DW_BITS]);
    end
    if (flip_dw >= 0) begin
      beat.write_parity[flip_dw] = ~beat.write_parity[flip_dw];
    end
    return beat;
  endfunction

  // Next edge with both buses idle
  task automatic step();
    @(posedge clock);
    cmd_in    <= '0;
    buffer_in <= '0;
  endtask

  task automatic issue_command(
    input logic [`AFU_TAG_BITS-1:0]    tag,
    input logic [`AFU_CU_ID_BITS-1:0]  cu_id,
    input afu_pkg::cmd_type_t          kind
  );
    afu_pkg::cmd_issue_t cmd;
    cmd.valid    = 1'b1;
    cmd.tag      = tag;
    cmd.cu_id    = cu_id;
    cmd.cmd_type = kind;
    step();
    cmd_in <= cmd;
  endtask

  task automatic send_beat(input afu_pkg::buffer_write_t beat);
    step();
    buffer_in <= beat;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic expect_equal(
    input string                    test_name,
    input string                    what,
    input logic [`AFU_LINE_BITS-1:0] expected,
    input logic [`AFU_LINE_BITS-1:0] actual
  );
    assert (expected === actual)
    else begin
      $display("mismatch in %s: %s expected %0h, actual %0h",
               test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Cycle numbers count from the last beat's drive edge and 0 means never
  task automatic observe(
    input  string                test_name,
    input  int                   cycles,
    input  int                   line_at,
    input  int                   err_at,
    input  logic [1:0]           err_val,
    input  int                   lerr_at,
    output afu_pkg::full_line_t  line
  );
    line = '0;
    for (int c = 1; c <= cycles; c++) begin
      step();
      @(negedge clock);  // Outputs settled
      expect_equal(test_name, "line_out.valid", (c == line_at), line_out.valid);
      expect_equal(test_name, "data_read_error", (c == err_at) ? err_val : 2'b00,
                   data_read_error);
      expect_equal(test_name, "line_error", (c == lerr_at), line_error);
      if (c == line_at) begin
        line = line_out;
      end
    end
  endtask

  task automatic check_line(
    input string                          test_name,
    input afu_pkg::full_line_t            line,
    input logic                           read_data,
    input logic                           wed_data,
    input logic [`AFU_CU_ID_BITS-1:0]     cu_id,
    input logic [`AFU_TAG_BITS-1:0]       tag,
    input logic [`AFU_LINE_BITS-1:0]      data
  );
    expect_equal(test_name, "line_out.read_data", read_data, line.read_data);
    expect_equal(test_name, "line_out.wed_data", wed_data, line.wed_data);
    expect_equal(test_name, "line_out.cu_id", cu_id, line.cu_id);
    expect_equal(test_name, "line_out.tag", tag, line.tag);
    expect_equal(test_name, "line_out.data", data, line.data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    repeat (RESET_CYCLES) @(posedge clock);
    rstn    <= 1'b1;
    enabled <= 1'b1;
    @(negedge clock);
    expect_equal("reset", "line_out.valid", 1'b0, line_out.valid);
    expect_equal("reset", "data_read_error", 2'b00, data_read_error);
    expect_equal("reset", "line_error", 1'b0, line_error);
  endtask

  // Two clean halves of one command checked field by field
  task automatic pair_test(
    input string                       test_name,
    input logic [`AFU_TAG_BITS-1:0]    tag,
    input logic [`AFU_CU_ID_BITS-1:0]  cu_id,
    input afu_pkg::cmd_type_t          kind
  );
    logic [`AFU_HALF_LINE_BITS-1:0] d0;
    logic [`AFU_HALF_LINE_BITS-1:0] d1;
    afu_pkg::full_line_t            line;
    d0 = random_half();
    d1 = random_half();
    issue_command(tag, cu_id, kind);
    send_beat(make_beat(tag, 1'b0, d0, 1'b0, -1));
    send_beat(make_beat(tag, 1'b1, d1, 1'b0, -1));
    observe(test_name, 5, 3, 0, 2'b00, 0, line);
    check_line(test_name, line, kind == afu_pkg::CMD_READ, kind == afu_pkg::CMD_WED,
               cu_id, tag, {d1, d0});
  endtask

  // Second half carries the bad parity
  task automatic parity_test(
    input string                     test_name,
    input logic [`AFU_TAG_BITS-1:0]  tag,
    input logic                      flip_tag,
    input int                        flip_dw,
    input logic [1:0]                err_val
  );
    afu_pkg::full_line_t line;
    issue_command(tag, 4'd1, afu_pkg::CMD_READ);
    send_beat(make_beat(tag, 1'b0, random_half(), 1'b0, -1));
    send_beat(make_beat(tag, 1'b1, random_half(), flip_tag, flip_dw));
    observe(test_name, 5, 3, 3, err_val, 0, line);
  endtask

  task automatic enable_gating_test();
    afu_pkg::full_line_t line;
    issue_command(8'h40, 4'd2, afu_pkg::CMD_READ);
    send_beat(make_beat(8'h40, 1'b0, random_half(), 1'b0, -1));
    enabled <= 1'b0;
    send_beat(make_beat(8'h40, 1'b1, random_half(), 1'b0, -1));
    observe("enable_gating", 10, 0, 0, 2'b00, 0, line);
    step();
    enabled <= 1'b1;
  endtask

  task automatic out_of_order_test();
    afu_pkg::full_line_t line;
    // Half 1 with nothing pending
    issue_command(8'h21, 4'd6, afu_pkg::CMD_READ);
    send_beat(make_beat(8'h21, 1'b1, random_half(), 1'b0, -1));
    observe("unpaired_half", 5, 0, 0, 2'b00, 3, line);
    // Half 1 of another tag than the pending half 0
    issue_command(8'h30, 4'd7, afu_pkg::CMD_READ);
    issue_command(8'h31, 4'd7, afu_pkg::CMD_READ);
    send_beat(make_beat(8'h30, 1'b0, random_half(), 1'b0, -1));
    send_beat(make_beat(8'h31, 1'b1, random_half(), 1'b0, -1));
    observe("tag_mismatch", 5, 0, 0, 2'b00, 3, line);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog and main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #((RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST) * CLOCK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin
    wait (UUT.u_read_data_control.u_read_data_checker.failure_count != 0);
    $display("bound assertion checker reported a failure");
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin
    rstn       = 1'b0;
    enabled    = 1'b0;
    cmd_in     = '0;
    buffer_in  = '0;
    lfsr_state = 16'd5;  // Seed

    apply_reset();
    pair_test("read_line", 8'h12, 4'd3, afu_pkg::CMD_READ);
    pair_test("wed_line", 8'h13, 4'd5, afu_pkg::CMD_WED);
    parity_test("data_parity", 8'h14, 1'b0, 5, 2'b10);
    parity_test("tag_parity", 8'h15, 1'b1, -1, 2'b01);
    enable_gating_test();
    out_of_order_test();
    repeat (3) step();

    if (UUT.u_read_data_control.u_read_data_checker.failure_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("bound assertion checker reported %0d failures",
               UUT.u_read_data_control.u_read_data_checker.failure_count);
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

// ==== list.f ====
+incdir+include
hdl/afu_pkg.sv
hdl/cmd_tag_table.sv
hdl/read_data_control.sv
hdl/read_line_assembler.sv
hdl/read_data_top.sv
tests/read_data_checker.sv
tests/read_data_tb.sv
